// File: design/axil_regs_params.svh
// Bus widths, register count and ID constant for the AXI4-Lite register block
`ifndef AXIL_REGS_PARAMS_SVH
`define AXIL_REGS_PARAMS_SVH

// AXI4-Lite bus geometry
`define AXIL_ADDR_W   12           // Byte address width
`define AXIL_DATA_W   32           // One register per data word
`define AXIL_STRB_W   4            // One strobe per byte lane

// Register file geometry
`define REG_COUNT     8            // Seven RW words plus the ID word
`define REG_IDX_W     3            // Word index, address bits 4:2

// Read-only identification word, last register
`define REG_ID_VALUE  32'h4158_5201

`endif

// File: design/axil_regs_pkg.sv
// Register address union and AXI response codes for the register block
`include "axil_regs_params.svh"

package axil_regs_pkg;

    // Word-aligned decode of a register address
    typedef struct packed {
        logic [`AXIL_ADDR_W-`REG_IDX_W-3:0] upper;      // Nonzero means out of range
        logic [`REG_IDX_W-1:0]              idx;        // Register index
        logic [1:0]                         byte_off;   // Ignored, accesses are whole words
    } reg_addr_s;

    // Same 12 bits seen raw by the front ends, decoded by the bank
    typedef union packed {
        logic [`AXIL_ADDR_W-1:0] raw;
        reg_addr_s               fields;
    } reg_addr_u;

    // BRESP / RRESP codes
    localparam logic [1:0] resp_okay = 2'b00;   // Only code this block returns

endpackage

// File: design/reg_bus_if.sv
// reg_wr_if and reg_rd_if register-bus interfaces between front ends and bank
`timescale 1ns/1ns
`include "axil_regs_params.svh"

// Write access, en held until the ack cycle
interface reg_wr_if;

    axil_regs_pkg::reg_addr_u  addr;   // Captured AW address
    logic [`AXIL_DATA_W-1:0]   data;   // Captured W data
    logic [`AXIL_STRB_W-1:0]   strb;   // Byte enables
    logic                      en;     // Access request
    logic                      ack;    // Write done this cycle

    // Front end requests, bank acknowledges
    modport front (
        output addr, data, strb, en,
        input  ack
    );

    modport bank (
        input  addr, data, strb, en,
        output ack
    );

endinterface

// Read access, data valid with ack
interface reg_rd_if;

    axil_regs_pkg::reg_addr_u  addr;   // Captured AR address
    logic                      en;     // One-cycle request
    logic [`AXIL_DATA_W-1:0]   data;   // Read word
    logic                      ack;    // Data valid

    modport front (
        output addr, en,
        input  data, ack
    );

    modport bank (
        input  addr, en,
        output data, ack
    );

endinterface

// File: design/axil_reg_wr.sv
// AXI4-Lite write front end joining AW and W beats into one register write
`timescale 1ns/1ns
`include "axil_regs_params.svh"

module axil_reg_wr (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic [`AXIL_ADDR_W-1:0]  s_axil_awaddr,
    input  logic [2:0]               s_axil_awprot,    // Accepted, not decoded
    input  logic                     s_axil_awvalid,
    output logic                     s_axil_awready,
    input  logic [`AXIL_DATA_W-1:0]  s_axil_wdata,
    input  logic [`AXIL_STRB_W-1:0]  s_axil_wstrb,
    input  logic                     s_axil_wvalid,
    output logic                     s_axil_wready,
    output logic [1:0]               s_axil_bresp,
    output logic                     s_axil_bvalid,
    input  logic                     s_axil_bready,
    reg_wr_if.front                  wr
);

    logic                      aw_held;      // Address holding register full
    logic                      w_held;       // Data holding register full
    logic                      bvalid_q;
    logic                      en_q;
    logic                      aw_held_nxt;
    logic                      w_held_nxt;
    logic                      bvalid_nxt;
    logic                      aw_fire;
    logic                      w_fire;
    logic                      wr_done;
    axil_regs_pkg::reg_addr_u  awaddr_q;
    logic [`AXIL_DATA_W-1:0]   wdata_q;
    logic [`AXIL_STRB_W-1:0]   wstrb_q;

    // Channels accepted independently, in either order
    assign aw_fire = s_axil_awvalid && !aw_held;
    assign w_fire  = s_axil_wvalid && !w_held;
    assign wr_done = en_q && wr.ack;       // Bank ack is same cycle

    always_comb begin
        aw_held_nxt = aw_held;
        w_held_nxt  = w_held;
        bvalid_nxt  = bvalid_q && !s_axil_bready;   // Drop on B transfer
        // Completed write frees both holders, opens B
        if (wr_done) begin
            aw_held_nxt = 1'b0;
            w_held_nxt  = 1'b0;
            bvalid_nxt  = 1'b1;
        end
        if (aw_fire)
            aw_held_nxt = 1'b1;
        if (w_fire)
            w_held_nxt = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
            bvalid_q <= 1'b0;
            en_q     <= 1'b0;
        end else begin
            aw_held  <= aw_held_nxt;
            w_held   <= w_held_nxt;
            bvalid_q <= bvalid_nxt;
            en_q     <= aw_held_nxt && w_held_nxt && !bvalid_nxt;   // No request while B pending
        end
    end

    // Beat payloads
    always_ff @(posedge clk) begin
        if (aw_fire)
            awaddr_q.raw <= s_axil_awaddr;
        if (w_fire) begin
            wdata_q <= s_axil_wdata;
            wstrb_q <= s_axil_wstrb;
        end
    end

    assign s_axil_awready = !aw_held;
    assign s_axil_wready  = !w_held;
    assign s_axil_bvalid  = bvalid_q;
    assign s_axil_bresp   = axil_regs_pkg::resp_okay;

    assign wr.addr = awaddr_q;
    assign wr.data = wdata_q;
    assign wr.strb = wstrb_q;
    assign wr.en   = en_q;

endmodule

// File: design/axil_reg_rd.sv
// AXI4-Lite read front end turning AR into a register read and returning R
`timescale 1ns/1ns
`include "axil_regs_params.svh"

module axil_reg_rd (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic [`AXIL_ADDR_W-1:0]  s_axil_araddr,
    input  logic [2:0]               s_axil_arprot,    // Accepted, not decoded
    input  logic                     s_axil_arvalid,
    output logic                     s_axil_arready,
    output logic [`AXIL_DATA_W-1:0]  s_axil_rdata,
    output logic [1:0]               s_axil_rresp,
    output logic                     s_axil_rvalid,
    input  logic                     s_axil_rready,
    reg_rd_if.front                  rd
);

    logic                      ar_held;      // Read in progress, blocks AR
    logic                      en_q;
    logic                      rvalid_q;
    logic                      ar_fire;
    logic                      r_fire;
    axil_regs_pkg::reg_addr_u  araddr_q;
    logic [`AXIL_DATA_W-1:0]   rdata_q;

    assign ar_fire = s_axil_arvalid && !ar_held;
    assign r_fire  = rvalid_q && s_axil_rready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ar_held  <= 1'b0;
            en_q     <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            en_q <= ar_fire;                   // Single-cycle request
            // Held from AR transfer until R transfer
            if (ar_fire)
                ar_held <= 1'b1;
            else if (r_fire)
                ar_held <= 1'b0;
            if (rd.ack)
                rvalid_q <= 1'b1;              // Data arrives, open R
            else if (r_fire)
                rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire)
            araddr_q.raw <= s_axil_araddr;
        if (rd.ack)
            rdata_q <= rd.data;                // Stable while rvalid waits
    end

    assign s_axil_arready = !ar_held;
    assign s_axil_rvalid  = rvalid_q;
    assign s_axil_rdata   = rdata_q;
    assign s_axil_rresp   = axil_regs_pkg::resp_okay;

    assign rd.addr = araddr_q;
    assign rd.en   = en_q;

endmodule

// File: design/reg_bank.sv
// Eight-word register bank, byte-strobe writes, read-only ID word, registered reads
`timescale 1ns/1ns
`include "axil_regs_params.svh"

module reg_bank (
    input  logic     clk,
    input  logic     rstn,
    reg_wr_if.bank   wr,
    reg_rd_if.bank   rd
);

    // Last index holds the ID constant, no storage behind it
    localparam logic [`REG_IDX_W-1:0] id_idx = `REG_IDX_W'(`REG_COUNT - 1);

    logic [`AXIL_DATA_W-1:0]  regs [`REG_COUNT-1];   // Writable words 0..6
    logic [`AXIL_DATA_W-1:0]  rd_word;
    logic                     wr_hit;

    assign wr.ack = wr.en;                       // Writes finish in the request cycle

    // In range and not the ID word
    assign wr_hit = wr.en && (wr.addr.fields.upper == '0) && (wr.addr.fields.idx != id_idx);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < `REG_COUNT - 1; i++)
                regs[i] <= '0;
        end else if (wr_hit) begin
            // Merge enabled byte lanes only
            for (int b = 0; b < `AXIL_STRB_W; b++) begin
                if (wr.strb[b])
                    regs[wr.addr.fields.idx][8*b +: 8] <= wr.data[8*b +: 8];
            end
        end
    end

    // Read decode
    always_comb begin
        if (rd.addr.fields.upper != '0)
            rd_word = '0;                        // Outside the block
        else if (rd.addr.fields.idx == id_idx)
            rd_word = `REG_ID_VALUE;
        else
            rd_word = regs[rd.addr.fields.idx];
    end

    // Ack one cycle behind en
    always_ff @(posedge clk) begin
        if (!rstn)
            rd.ack <= 1'b0;
        else
            rd.ack <= rd.en;
    end

    always_ff @(posedge clk) begin
        if (rd.en)
            rd.data <= rd_word;
    end

endmodule

// File: design/axil_regs_top.sv
// Top level of the AXI4-Lite register block, front ends and bank
`timescale 1ns/1ns
`include "axil_regs_params.svh"

module axil_regs_top (
    input  logic                     clk,
    input  logic                     rstn,
    // Write address / data / response
    input  logic [`AXIL_ADDR_W-1:0]  s_axil_awaddr,
    input  logic [2:0]               s_axil_awprot,
    input  logic                     s_axil_awvalid,
    output logic                     s_axil_awready,
    input  logic [`AXIL_DATA_W-1:0]  s_axil_wdata,
    input  logic [`AXIL_STRB_W-1:0]  s_axil_wstrb,
    input  logic                     s_axil_wvalid,
    output logic                     s_axil_wready,
    output logic [1:0]               s_axil_bresp,
    output logic                     s_axil_bvalid,
    input  logic                     s_axil_bready,
    // Read address / data
    input  logic [`AXIL_ADDR_W-1:0]  s_axil_araddr,
    input  logic [2:0]               s_axil_arprot,
    input  logic                     s_axil_arvalid,
    output logic                     s_axil_arready,
    output logic [`AXIL_DATA_W-1:0]  s_axil_rdata,
    output logic [1:0]               s_axil_rresp,
    output logic                     s_axil_rvalid,
    input  logic                     s_axil_rready
);

    reg_wr_if wr_bus ();   // Write front end to bank
    reg_rd_if rd_bus ();   // Read front end to bank

    axil_reg_wr u_wr (
        .clk            (clk),
        .rstn           (rstn),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awprot  (s_axil_awprot),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .wr             (wr_bus)
    );

    axil_reg_rd u_rd (
        .clk            (clk),
        .rstn           (rstn),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arprot  (s_axil_arprot),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .rd             (rd_bus)
    );

    // Serves both front ends, reads and writes overlap freely
    reg_bank u_bank (
        .clk  (clk),
        .rstn (rstn),
        .wr   (wr_bus),
        .rd   (rd_bus)
    );

endmodule

// File: verif/axil_regs_checker.sv
// Concurrent assertions on B and R handshakes and the register write request
`timescale 1ns/1ns

module axil_regs_checker (
    input logic        clk,
    input logic        rstn,
    input logic        s_axil_bvalid,
    input logic        s_axil_bready,
    input logic [1:0]  s_axil_bresp,
    input logic        s_axil_rvalid,
    input logic        s_axil_rready,
    input logic [1:0]  s_axil_rresp,
    input logic        wr_en                 // Register-bus write request
);

    // Valid held until taken
    bvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
        else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
        else $error("rvalid dropped before rready");

    bresp_okay: assert property (@(posedge clk) disable iff (!rstn)
        s_axil_bvalid |-> s_axil_bresp == 2'b00)
        else $error("bresp not OKAY");

    rresp_okay: assert property (@(posedge clk) disable iff (!rstn)
        s_axil_rvalid |-> s_axil_rresp == 2'b00)
        else $error("rresp not OKAY");

    // No new write while a response waits
    wr_en_quiet: assert property (@(posedge clk) disable iff (!rstn)
        $rose(wr_en) |-> !s_axil_bvalid)
        else $error("register write requested while bvalid high");

endmodule

bind axil_regs_top axil_regs_checker u_checker (
    .clk           (clk),
    .rstn          (rstn),
    .s_axil_bvalid (s_axil_bvalid),
    .s_axil_bready (s_axil_bready),
    .s_axil_bresp  (s_axil_bresp),
    .s_axil_rvalid (s_axil_rvalid),
    .s_axil_rready (s_axil_rready),
    .s_axil_rresp  (s_axil_rresp),
    .wr_en         (wr_bus.en)
);

// File: verif/axil_regs_tb.sv
// Data-driven testbench for the AXI4-Lite register block with clock, reset, driver and watchdog
`timescale 1ns/1ns
`include "axil_regs_params.svh"

module axil_regs_tb;

    logic                     clk;
    logic                     rstn;
    logic [`AXIL_ADDR_W-1:0]  s_axil_awaddr;
    logic [2:0]               s_axil_awprot;
    logic                     s_axil_awvalid;
    logic                     s_axil_awready;
    logic [`AXIL_DATA_W-1:0]  s_axil_wdata;
    logic [`AXIL_STRB_W-1:0]  s_axil_wstrb;
    logic                     s_axil_wvalid;
    logic                     s_axil_wready;
    logic [1:0]               s_axil_bresp;
    logic                     s_axil_bvalid;
    logic                     s_axil_bready;
    logic [`AXIL_ADDR_W-1:0]  s_axil_araddr;
    logic [2:0]               s_axil_arprot;
    logic                     s_axil_arvalid;
    logic                     s_axil_arready;
    logic [`AXIL_DATA_W-1:0]  s_axil_rdata;
    logic [1:0]               s_axil_rresp;
    logic                     s_axil_rvalid;
    logic                     s_axil_rready;

    // One entry per data file line
    string                    t_name [$];
    string                    t_op   [$];
    logic [`AXIL_ADDR_W-1:0]  t_addr [$];
    logic [`AXIL_DATA_W-1:0]  t_data [$];
    logic [`AXIL_STRB_W-1:0]  t_strb [$];
    logic [`AXIL_DATA_W-1:0]  t_exp  [$];
    int                       n_tests;
    bit                       loaded;        // Watchdog starts counting once set
    bit                       b_busy;        // B of the last write still outstanding
    string                    cur_name;      // Test in progress, for error lines

    axil_regs_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;               // 4 ns period
    end

    task automatic stop_with_fail(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic load_tests();
        int                       fd;
        int                       cnt;
        string                    line;
        string                    name;
        string                    op;
        logic [`AXIL_ADDR_W-1:0]  addr;
        logic [`AXIL_DATA_W-1:0]  data;
        logic [`AXIL_STRB_W-1:0]  strb;
        logic [`AXIL_DATA_W-1:0]  exp;
        fd = $fopen("verif/axil_regs_testdata.txt", "r");
        if (fd == 0)
            stop_with_fail("Cannot open verif/axil_regs_testdata.txt");
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0)
                break;
            if (line.len() < 2 || line[0] == "#")
                continue;                    // Blank or comment
            cnt = $sscanf(line, "%s %s %h %h %h %h", name, op, addr, data, strb, exp);
            if (cnt != 6 || (op != "W" && op != "R"))
                stop_with_fail({"Malformed test line: ", line});
            t_name.push_back(name);
            t_op.push_back(op);
            t_addr.push_back(addr);
            t_data.push_back(data);
            t_strb.push_back(strb);
            t_exp.push_back(exp);
        end
        $fclose(fd);
        n_tests = t_name.size();
    endtask

    // Beat drivers, entered and left on a falling edge
    task automatic send_aw(input logic [`AXIL_ADDR_W-1:0] addr, input int skew);
        repeat (skew) @(negedge clk);
        s_axil_awaddr  = addr;
        s_axil_awvalid = 1'b1;
        while (!s_axil_awready)
            @(negedge clk);
        @(negedge clk);                      // Transfer on the rising edge in between
        s_axil_awvalid = 1'b0;
    endtask

    task automatic send_w(input logic [`AXIL_DATA_W-1:0] data,
                          input logic [`AXIL_STRB_W-1:0] strb, input int skew);
        repeat (skew) @(negedge clk);
        s_axil_wdata  = data;
        s_axil_wstrb  = strb;
        s_axil_wvalid = 1'b1;
        while (!s_axil_wready)
            @(negedge clk);
        @(negedge clk);
        s_axil_wvalid = 1'b0;
    endtask

    task automatic take_b(input string name, input int delay);
        repeat (delay) @(negedge clk);       // Back-pressure on B
        s_axil_bready = 1'b1;
        while (!s_axil_bvalid)
            @(negedge clk);
        assert (s_axil_bresp == 2'b00) else
            stop_with_fail($sformatf("MISMATCH %s bresp expected 0 actual %0d",
                                     name, s_axil_bresp));
        @(negedge clk);
        s_axil_bready = 1'b0;
    endtask

    task automatic write_word(input logic [`AXIL_ADDR_W-1:0] addr,
                              input logic [`AXIL_DATA_W-1:0] data,
                              input logic [`AXIL_STRB_W-1:0] strb);
        int    skew;
        int    aw_skew;
        int    w_skew;
        int    b_delay;
        string name;
        skew    = $urandom % 4;
        aw_skew = 0;
        w_skew  = 0;
        b_delay = $urandom % 5;
        name    = cur_name;
        if ($urandom % 2 == 0)               // Random order of AW and W
            w_skew = skew;
        else
            aw_skew = skew;
        // Beats may land while the previous B still waits
        fork
            send_aw(addr, aw_skew);
            send_w(data, strb, w_skew);
        join
        wait (!b_busy);
        b_busy = 1'b1;
        fork
            begin
                take_b(name, b_delay);
                b_busy = 1'b0;
            end
        join_none
    endtask

    task automatic read_and_check(input logic [`AXIL_ADDR_W-1:0] addr,
                                  input logic [`AXIL_DATA_W-1:0] exp, input int delay);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        while (!s_axil_arready)
            @(negedge clk);
        @(negedge clk);
        s_axil_arvalid = 1'b0;
        repeat (delay) @(negedge clk);
        s_axil_rready = 1'b1;
        while (!s_axil_rvalid)
            @(negedge clk);
        assert (s_axil_rdata == exp) else
            stop_with_fail($sformatf("MISMATCH %s rdata expected %08h actual %08h",
                                     cur_name, exp, s_axil_rdata));
        assert (s_axil_rresp == 2'b00) else
            stop_with_fail($sformatf("MISMATCH %s rresp expected 0 actual %0d",
                                     cur_name, s_axil_rresp));
        @(negedge clk);
        s_axil_rready = 1'b0;
    endtask

    initial begin
        void'($urandom(27));
        rstn           = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awprot  = 3'b000;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arprot  = 3'b000;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        b_busy         = 1'b0;
        cur_name       = "reset";
        load_tests();
        loaded = 1'b1;
        repeat (16) @(negedge clk);
        rstn = 1'b1;
        // Quiet bus before the first request
        repeat (4) begin
            @(negedge clk);
            assert (!s_axil_bvalid && !s_axil_rvalid) else
                stop_with_fail("A response became valid before any request was sent");
        end
        for (int i = 0; i < n_tests; i++) begin
            cur_name = t_name[i];
            if (t_op[i] == "W") begin
                write_word(t_addr[i], t_data[i], t_strb[i]);
            end else begin
                wait (!b_busy);              // Earlier write fully done
                read_and_check(t_addr[i], t_exp[i], $urandom % 5);
            end
        end
        wait (!b_busy);
        $display("Test completed successfully");
        $finish;
    end

    // Budget of 40 cycles per access plus reset
    initial begin
        wait (loaded);
        repeat (n_tests * 40 + 16) @(posedge clk);
        stop_with_fail($sformatf("Timeout, a handshake never completed during test %s",
                                 cur_name));
    end

endmodule

// File: verif/axil_regs_testdata.txt
# name op(W=write R=read) addr(hex) data(hex) strobe(hex) expected_read(hex)
# Writes ignore the expected column; reads ignore data and strobe
rst_r0    R 000 00000000 0 00000000
rst_r5    R 014 00000000 0 00000000
id_rst    R 01C 00000000 0 41585201
full_w0   W 000 A5A50000 F 00000000
full_w1   W 004 11223344 F 00000000
full_w2   W 008 DEADBEEF F 00000000
full_w3   W 00C 0BADF00D F 00000000
full_w4   W 010 CAFEBABE F 00000000
full_w5   W 014 12345678 F 00000000
full_w6   W 018 87654321 F 00000000
full_r0   R 000 00000000 0 A5A50000
full_r1   R 004 00000000 0 11223344
full_r2   R 008 00000000 0 DEADBEEF
full_r3   R 00C 00000000 0 0BADF00D
full_r4   R 010 00000000 0 CAFEBABE
full_r5   R 014 00000000 0 12345678
full_r6   R 018 00000000 0 87654321
part_w2   W 008 01020304 5 00000000
part_r2   R 008 00000000 0 DE02BE04
id_w      W 01C FFFFFFFF F 00000000
id_r      R 01C 00000000 0 41585201
oor_w     W 020 FFFFFFFF F 00000000
oor_r     R 020 00000000 0 00000000
oor_r0    R 000 00000000 0 A5A50000

// File: build.f
+incdir+design
design/axil_regs_pkg.sv
design/reg_bus_if.sv
design/axil_reg_wr.sv
design/axil_reg_rd.sv
design/reg_bank.sv
design/axil_regs_top.sv
verif/axil_regs_checker.sv
verif/axil_regs_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the register block testbench with Verilator, run it, and check the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module axil_regs_tb \
    -Mdir obj_dir -o axil_regs_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/axil_regs_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
echo "Simulation passed"
exit 0
